//--- compile.f
source/fetch_pkg.sv
source/thread_pc.sv
source/thread_scheduler.sv
source/fetch_select.sv
source/fetch_stage.sv
sim/fetch_stage_sva.sv
sim/fetch_stage_tb.sv

//--- sim/fetch_stage_tb.sv
////////////////////////////////////////
// directed testbench for the fetch stage. a combinational
// memory model and a per-thread PC reference run beside
// the DUT and the outputs are compared after every clock edge
////////////////////////////////////////
`timescale 1ns/10ps

module fetch_stage_tb
	import fetch_pkg::*;
();

	localparam int MAX_CYCLES = 2000;

	logic                        clock;
	logic                        reset;
	logic                        two_threads;
	logic                        rs_stall;
	logic                        rat_stall;
	logic [THREAD_COUNT-1:0]     rob_stall;
	logic [THREAD_COUNT-1:0]     hazard_stall;
	logic [THREAD_COUNT-1:0]     branch_taken;
	logic [PC_WIDTH-1:0]         target_pc [THREAD_COUNT];
	logic [MEM_WIDTH-1:0]        imem_data;
	logic                        imem_valid;
	logic [PC_WIDTH-1:0]         imem_addr;
	logic [THREAD_IDX_WIDTH-1:0] fetch_thread;
	logic [INST_WIDTH-1:0]       inst0;
	logic [INST_WIDTH-1:0]       inst1;
	logic                        inst0_valid;
	logic                        inst1_valid;
	logic [PC_WIDTH-1:0]         next_pc;

	// reference state updated once per edge
	sched_state_t          ref_state;
	int                    ref_rot;
	int                    ref_last;
	logic [PC_WIDTH-1:0]   ref_pc [THREAD_COUNT];
	logic                  ref_v0 [THREAD_COUNT];
	logic                  ref_v1 [THREAD_COUNT];
	logic [INST_WIDTH-1:0] ref_i0 [THREAD_COUNT];
	logic [INST_WIDTH-1:0] ref_i1 [THREAD_COUNT];
	logic [31:0]           lfsr;
	int                    errors;
	int                    cycles;

	fetch_stage i_dut (.*);

	always #20 clock = ~clock;

	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// memory model and helpers
	////////////////////////////////////////

	function automatic logic [INST_WIDTH-1:0] mem_word(input logic [PC_WIDTH-1:0] addr);
		return addr[31:0] ^ 32'hc0de_0000;
	endfunction

	assign imem_data = {mem_word(imem_addr + 4), mem_word(imem_addr)};

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic random_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic int granted_thread();
		if (ref_state == SCHED_SINGLE)
			return 0;
		if (ref_state == SCHED_ROTATE)
			return ref_rot;
		return -1; // start cycle
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	// advance the reference over one edge with the inputs now applied
	task automatic update_reference();
		int                  g;
		logic                fire;
		logic [PC_WIDTH-1:0] base;
		g = granted_thread();
		for (int t = 0; t < THREAD_COUNT; t++)
		begin
			fire = (g == t) && !rs_stall && !rat_stall && !rob_stall[t] &&
				!hazard_stall[t] && imem_valid;
			ref_v0[t] = 1'b0;
			ref_v1[t] = 1'b0;
			if (reset)
				ref_pc[t] = PC_WIDTH'(t) * 64'h1000;
			else if (branch_taken[t])
				ref_pc[t] = target_pc[t]; // squashes any fetch
			else if (fire)
			begin
				base      = {ref_pc[t][PC_WIDTH-1:3], 3'b000};
				ref_i0[t] = mem_word(base);
				ref_i1[t] = mem_word(base + 4);
				ref_v0[t] = !ref_pc[t][2];
				ref_v1[t] = 1'b1;
				ref_pc[t] = ref_pc[t][2] ? ref_pc[t] + 4 : ref_pc[t] + 8;
			end
		end
		ref_last = (reset || g < 0) ? 0 : g;
		if (!reset && ref_state == SCHED_ROTATE && two_threads)
			ref_rot = (ref_rot + 1) % THREAD_COUNT;
		else
			ref_rot = 0;
		if (reset)
			ref_state = SCHED_START;
		else if (two_threads)
			ref_state = SCHED_ROTATE;
		else
			ref_state = SCHED_SINGLE;
	endtask

	// one edge, then compare the DUT with the reference
	task automatic clock_cycle();
		int                  g;
		logic [PC_WIDTH-1:0] exp_addr;
		update_reference();
		@(posedge clock);
		#1;
		g        = granted_thread();
		exp_addr = '0;
		if (g >= 0)
			exp_addr = {ref_pc[g][PC_WIDTH-1:3], 3'b000};
		if (imem_addr !== exp_addr)
			report_mismatch("imem_addr", imem_addr, exp_addr);
		if (fetch_thread !== ref_last)
			report_mismatch("fetch_thread", fetch_thread, ref_last);
		if (inst0_valid !== ref_v0[ref_last])
			report_mismatch("inst0_valid", inst0_valid, ref_v0[ref_last]);
		if (inst1_valid !== ref_v1[ref_last])
			report_mismatch("inst1_valid", inst1_valid, ref_v1[ref_last]);
		if (ref_v0[ref_last] && inst0 !== ref_i0[ref_last])
			report_mismatch("inst0", inst0, ref_i0[ref_last]);
		if (ref_v1[ref_last] && inst1 !== ref_i1[ref_last])
			report_mismatch("inst1", inst1, ref_i1[ref_last]);
		if (next_pc !== ref_pc[ref_last])
			report_mismatch("next_pc", next_pc, ref_pc[ref_last]);
		#1; // inputs change 2 ns after the edge
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic test_reset();
		reset = 1'b1;
		repeat (2) clock_cycle();
		reset = 1'b0;
		clock_cycle(); // start cycle with nothing granted
	endtask

	task automatic test_streams(input logic both, input int count);
		two_threads = both;
		repeat (count) clock_cycle();
	endtask

	task automatic test_stalls(input int count);
		two_threads = 1'b1;
		repeat (count)
		begin
			rs_stall   = random_bit() & random_bit() & random_bit();
			rat_stall  = random_bit() & random_bit() & random_bit();
			imem_valid = !(random_bit() & random_bit());
			for (int t = 0; t < THREAD_COUNT; t++)
			begin
				rob_stall[t]    = random_bit() & random_bit();
				hazard_stall[t] = random_bit() & random_bit();
			end
			clock_cycle();
		end
		rs_stall     = 1'b0;
		rat_stall    = 1'b0;
		rob_stall    = '0;
		hazard_stall = '0;
		imem_valid   = 1'b1;
	endtask

	// redirect while the thread holds the grant, so its fetch is squashed
	task automatic redirect_thread(input int t, input logic [PC_WIDTH-1:0] target);
		int waited;
		while (granted_thread() != t)
			clock_cycle();
		branch_taken[t] = 1'b1;
		target_pc[t]    = target;
		clock_cycle();
		branch_taken[t] = 1'b0;
		waited          = 0;
		while (!(fetch_thread == t && inst1_valid) && waited < 10)
		begin
			clock_cycle();
			waited++;
		end
		if (waited >= 10)
		begin
			errors++;
			$display("thread %0d never fetched from branch target %h", t, target);
		end
		else if (target[2] && (inst0_valid !== 1'b0 || inst1 !== mem_word(target)))
			report_mismatch("upper-only pair at target", inst1, mem_word(target));
		else if (!target[2] && inst0 !== mem_word(target))
			report_mismatch("first pair at target", inst0, mem_word(target));
		repeat (6) clock_cycle(); // aligned stream after the target
	endtask

	initial
	begin
		clock        = 1'b0;
		reset        = 1'b1;
		two_threads  = 1'b0;
		rs_stall     = 1'b0;
		rat_stall    = 1'b0;
		rob_stall    = '0;
		hazard_stall = '0;
		branch_taken = '0;
		target_pc    = '{default: '0};
		imem_valid   = 1'b1;
		lfsr         = 32'h52e3_6c0a;
		errors       = 0;
		cycles       = 0;
		ref_state    = SCHED_START;
		ref_rot      = 0;
		ref_last     = 0;
		test_reset();
		test_streams(1'b0, 16);
		test_streams(1'b1, 16);
		test_stalls(120);
		redirect_thread(0, 64'h0000_2040);
		redirect_thread(1, 64'h0000_3104);
		redirect_thread(0, 64'h0000_0a0c);
		$display("fetch stage tests: %0d cycles, %0d errors, %0d assertion failures",
			cycles, errors, i_dut.i_sva.assert_failures);
		if (errors == 0 && i_dut.i_sva.assert_failures == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- sim/fetch_stage_sva.sv
////////////////////////////////////////
// concurrent checks on the fetch stage, bound into
// every fetch_stage instance from the testbench side
////////////////////////////////////////
`timescale 1ns/10ps

module fetch_stage_sva
	import fetch_pkg::*;
(
	input logic                        clock,
	input logic                        reset,
	input logic                        two_threads,
	input logic [THREAD_COUNT-1:0]     grant,
	input logic [PC_WIDTH-1:0]         imem_addr,
	input logic [THREAD_IDX_WIDTH-1:0] fetch_thread,
	input logic                        inst0_valid,
	input logic                        inst1_valid
);

	int assert_failures = 0; // failed assertion count

	addr_aligned: assert property (@(posedge clock) disable iff (reset)
		imem_addr[ALIGN_BITS-1:0] == '0)
		else
		begin
			$error("imem_addr %h is not word aligned", imem_addr);
			assert_failures++;
		end

	grant_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(grant))
		else
		begin
			$error("grant %b has more than one thread", grant);
			assert_failures++;
		end

	// covers the reset itself and the start cycle that follows it
	valids_after_reset: assert property (@(posedge clock)
		($past(reset) || $past(reset, 2)) |-> (!inst0_valid && !inst1_valid))
		else
		begin
			$error("instruction valid during reset or the start cycle");
			assert_failures++;
		end

	// once rotation has run for three edges each slot goes to the other thread
	fetch_alternates: assert property (@(posedge clock) disable iff (reset)
		($past(two_threads, 1) && $past(two_threads, 2) && $past(two_threads, 3) &&
		 !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
		|-> (fetch_thread != $past(fetch_thread)))
		else
		begin
			$error("fetch_thread %0d repeated in two-thread mode", fetch_thread);
			assert_failures++;
		end

endmodule

bind fetch_stage fetch_stage_sva i_sva (
	.clock        (clock),
	.reset        (reset),
	.two_threads  (two_threads),
	.grant        (grant),
	.imem_addr    (imem_addr),
	.fetch_thread (fetch_thread),
	.inst0_valid  (inst0_valid),
	.inst1_valid  (inst1_valid)
);

//--- source/fetch_stage.sv
////////////////////////////////////////
// instruction fetch stage of the two-thread core.
// scheduler, one PC unit per thread and the selector
// around a shared combinational instruction memory port
////////////////////////////////////////
`timescale 1ns/10ps

module fetch_stage
	import fetch_pkg::*;
(
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        two_threads,
	input  logic                        rs_stall,     // shared by all threads
	input  logic                        rat_stall,
	input  logic [THREAD_COUNT-1:0]     rob_stall,    // one per thread
	input  logic [THREAD_COUNT-1:0]     hazard_stall,
	input  logic [THREAD_COUNT-1:0]     branch_taken,
	input  logic [PC_WIDTH-1:0]         target_pc [THREAD_COUNT],
	input  logic [MEM_WIDTH-1:0]        imem_data,
	input  logic                        imem_valid,
	output logic [PC_WIDTH-1:0]         imem_addr,
	output logic [THREAD_IDX_WIDTH-1:0] fetch_thread,
	output logic [INST_WIDTH-1:0]       inst0,
	output logic [INST_WIDTH-1:0]       inst1,
	output logic                        inst0_valid,
	output logic                        inst1_valid,
	output logic [PC_WIDTH-1:0]         next_pc
);

	logic [THREAD_COUNT-1:0]     grant;
	logic [THREAD_IDX_WIDTH-1:0] last_thread;

	// per-unit results toward the selector
	logic [PC_WIDTH-1:0]     unit_fetch_addr [THREAD_COUNT];
	logic [INST_WIDTH-1:0]   unit_inst0 [THREAD_COUNT];
	logic [INST_WIDTH-1:0]   unit_inst1 [THREAD_COUNT];
	logic [THREAD_COUNT-1:0] unit_inst0_valid;
	logic [THREAD_COUNT-1:0] unit_inst1_valid;
	logic [PC_WIDTH-1:0]     unit_next_pc [THREAD_COUNT];

	thread_scheduler i_scheduler (
		.clock       (clock),
		.reset       (reset),
		.two_threads (two_threads),
		.grant       (grant),
		.last_thread (last_thread)
	);

	////////////////////////////////////////
	// one PC unit per thread
	////////////////////////////////////////

	for (genvar t = 0; t < THREAD_COUNT; t++)
	begin : g_thread
		thread_pc #(
			.THREAD_INDEX (t)
		) i_thread_pc (
			.clock        (clock),
			.reset        (reset),
			.fetch_enable (grant[t]),
			.branch_taken (branch_taken[t]),
			.target_pc    (target_pc[t]),
			.rs_stall     (rs_stall),
			.rat_stall    (rat_stall),
			.rob_stall    (rob_stall[t]),
			.hazard_stall (hazard_stall[t]),
			.imem_data    (imem_data),
			.imem_valid   (imem_valid),
			.fetch_addr   (unit_fetch_addr[t]),
			.inst0        (unit_inst0[t]),
			.inst1        (unit_inst1[t]),
			.inst0_valid  (unit_inst0_valid[t]),
			.inst1_valid  (unit_inst1_valid[t]),
			.next_pc      (unit_next_pc[t])
		);
	end

	fetch_select i_select (
		.grant            (grant),
		.last_thread      (last_thread),
		.unit_fetch_addr  (unit_fetch_addr),
		.unit_inst0       (unit_inst0),
		.unit_inst1       (unit_inst1),
		.unit_inst0_valid (unit_inst0_valid),
		.unit_inst1_valid (unit_inst1_valid),
		.unit_next_pc     (unit_next_pc),
		.imem_addr        (imem_addr),
		.fetch_thread     (fetch_thread),
		.inst0            (inst0),
		.inst1            (inst1),
		.inst0_valid      (inst0_valid),
		.inst1_valid      (inst1_valid),
		.next_pc          (next_pc)
	);

endmodule

//--- source/fetch_select.sv
////////////////////////////////////////
// combinational routing around the thread units.
// memory address from the granted unit, results from
// the unit that fetched in the previous cycle
////////////////////////////////////////
`timescale 1ns/10ps

module fetch_select
	import fetch_pkg::*;
(
	input  logic [THREAD_COUNT-1:0]     grant,
	input  logic [THREAD_IDX_WIDTH-1:0] last_thread,
	input  logic [PC_WIDTH-1:0]         unit_fetch_addr [THREAD_COUNT],
	input  logic [INST_WIDTH-1:0]       unit_inst0 [THREAD_COUNT],
	input  logic [INST_WIDTH-1:0]       unit_inst1 [THREAD_COUNT],
	input  logic [THREAD_COUNT-1:0]     unit_inst0_valid,
	input  logic [THREAD_COUNT-1:0]     unit_inst1_valid,
	input  logic [PC_WIDTH-1:0]         unit_next_pc [THREAD_COUNT],
	output logic [PC_WIDTH-1:0]         imem_addr,
	output logic [THREAD_IDX_WIDTH-1:0] fetch_thread,
	output logic [INST_WIDTH-1:0]       inst0,
	output logic [INST_WIDTH-1:0]       inst1,
	output logic                        inst0_valid,
	output logic                        inst1_valid,
	output logic [PC_WIDTH-1:0]         next_pc
);

	////////////////////////////////////////
	// memory side
	////////////////////////////////////////

	// grant is one-hot or zero, zero address when idle
	always_comb
	begin
		imem_addr = '0;
		for (int t = 0; t < THREAD_COUNT; t++)
		begin
			if (grant[t])
			begin
				imem_addr = unit_fetch_addr[t];
			end
		end
	end

	////////////////////////////////////////
	// output side
	////////////////////////////////////////

	// the registered pair belongs to last cycle's grant
	assign fetch_thread = last_thread;
	assign inst0        = unit_inst0[last_thread];
	assign inst1        = unit_inst1[last_thread];
	assign inst0_valid  = unit_inst0_valid[last_thread];
	assign inst1_valid  = unit_inst1_valid[last_thread];
	assign next_pc      = unit_next_pc[last_thread];

endmodule

//--- source/thread_scheduler.sv
////////////////////////////////////////
// decides each cycle which thread may fetch.
// one-hot grant out of a small state machine plus a
// rotation counter, and the index granted a cycle ago
////////////////////////////////////////
`timescale 1ns/10ps

module thread_scheduler
	import fetch_pkg::*;
(
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        two_threads,
	output logic [THREAD_COUNT-1:0]     grant,
	output logic [THREAD_IDX_WIDTH-1:0] last_thread
);

	sched_state_t                state;
	sched_state_t                state_next;
	logic [THREAD_IDX_WIDTH-1:0] rot_index;      // thread granted while rotating
	logic [THREAD_IDX_WIDTH-1:0] rot_index_next;
	logic [THREAD_IDX_WIDTH-1:0] grant_index;

	// mode follows two_threads from the next edge on
	assign state_next = two_threads ? SCHED_ROTATE : SCHED_SINGLE;

	// rotation always restarts at thread 0 on entry
	always_comb
	begin
		if (state == SCHED_ROTATE && state_next == SCHED_ROTATE)
		begin
			if (rot_index == THREAD_IDX_WIDTH'(THREAD_COUNT - 1))
				rot_index_next = '0;
			else
				rot_index_next = rot_index + 1'b1;
		end
		else
		begin
			rot_index_next = '0;
		end
	end

	always_comb
	begin
		grant       = '0;
		grant_index = '0;
		case (state)
			SCHED_SINGLE:
			begin
				grant[0] = 1'b1;
			end
			SCHED_ROTATE:
			begin
				grant[rot_index] = 1'b1;
				grant_index      = rot_index;
			end
			default:
			begin
				grant = '0; // start cycle, nobody fetches
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state       <= SCHED_START;
			rot_index   <= '0;
			last_thread <= '0;
		end
		else
		begin
			state       <= state_next;
			rot_index   <= rot_index_next;
			last_thread <= grant_index; // steers the output selector next cycle
		end
	end

endmodule

//--- source/thread_pc.sv
////////////////////////////////////////
// program counter of one hardware thread. merges the stalls,
// applies branch redirects, aligns the fetch address to the
// memory word and registers the returned instruction pair.
// one copy per thread, selected by THREAD_INDEX
////////////////////////////////////////
`timescale 1ns/10ps

module thread_pc
	import fetch_pkg::*;
#(
	parameter int THREAD_INDEX = 0
)
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_enable,   // grant from the scheduler
	input  logic                  branch_taken,   // one-cycle redirect strobe
	input  logic [PC_WIDTH-1:0]   target_pc,
	input  logic                  rs_stall,
	input  logic                  rat_stall,
	input  logic                  rob_stall,
	input  logic                  hazard_stall,
	input  logic [MEM_WIDTH-1:0]  imem_data,
	input  logic                  imem_valid,
	output logic [PC_WIDTH-1:0]   fetch_addr,
	output logic [INST_WIDTH-1:0] inst0,
	output logic [INST_WIDTH-1:0] inst1,
	output logic                  inst0_valid,
	output logic                  inst1_valid,
	output logic [PC_WIDTH-1:0]   next_pc
);

	localparam logic [THREAD_IDX_WIDTH-1:0] thread_id = THREAD_IDX_WIDTH'(THREAD_INDEX);

	logic [PC_WIDTH-1:0] pc;
	logic [PC_WIDTH-1:0] pc_next;
	logic                any_stall;
	logic                fetch_fire;
	logic                upper_only;

	////////////////////////////////////////
	// fetch decision
	////////////////////////////////////////

	assign any_stall  = rs_stall | rat_stall | rob_stall | hazard_stall;

	// a redirect squashes whatever fetch was going on this cycle
	assign fetch_fire = fetch_enable & ~any_stall & imem_valid & ~branch_taken;

	// pc points at the upper half of the pair
	assign upper_only = pc[ALIGN_BITS-1];

	// memory only sees word-aligned addresses
	assign fetch_addr = {pc[PC_WIDTH-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};

	assign next_pc = pc;

	// the word after the fetched one covers both cases,
	// pc + 8 when aligned and pc + 4 from the upper half
	always_comb
	begin
		if (branch_taken)
		begin
			pc_next = target_pc;
		end
		else if (fetch_fire)
		begin
			pc_next = fetch_addr + PC_WIDTH'(FETCH_BYTES);
		end
		else
		begin
			pc_next = pc;
		end
	end

	////////////////////////////////////////
	// registers
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc          <= PC_WIDTH'(thread_id) * THREAD_BASE_STRIDE;
			inst0_valid <= 1'b0;
			inst1_valid <= 1'b0;
		end
		else
		begin
			pc          <= pc_next;
			inst0_valid <= fetch_fire & ~upper_only; // lower slot dropped when misaligned
			inst1_valid <= fetch_fire;
		end
	end

	// instruction pair, only meaningful under the valids
	always_ff @(posedge clock)
	begin
		if (fetch_fire)
		begin
			inst0 <= imem_data[INST_WIDTH-1:0];
			inst1 <= imem_data[MEM_WIDTH-1:INST_WIDTH];
		end
	end

endmodule

//--- source/fetch_pkg.sv
////////////////////////////////////////
// shared widths, thread count, reset PC stride and
// scheduler states for the two-thread fetch stage.
// every fetch module imports this package by wildcard
////////////////////////////////////////

package fetch_pkg;

	////////////////////////////////////////
	// threads
	////////////////////////////////////////

	localparam int THREAD_COUNT = 2;          // hardware threads sharing the memory port

	// index width, kept at one bit even for a single thread
	localparam int THREAD_IDX_WIDTH = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1;

	////////////////////////////////////////
	// addresses and instructions
	////////////////////////////////////////

	localparam int PC_WIDTH   = 64;
	localparam int INST_WIDTH = 32;

	// one memory word carries an instruction pair
	localparam int FETCH_BYTES = 8;
	localparam int MEM_WIDTH   = FETCH_BYTES * 8;
	localparam int ALIGN_BITS  = $clog2(FETCH_BYTES); // low address bits inside a word

	// thread t starts at t * stride
	localparam logic [PC_WIDTH-1:0] THREAD_BASE_STRIDE = 'h1000;

	////////////////////////////////////////
	// scheduler
	////////////////////////////////////////

	typedef enum logic [1:0]
	{
		SCHED_START,  // idle cycle after reset, nobody granted
		SCHED_SINGLE, // thread 0 fetches every cycle
		SCHED_ROTATE  // round-robin over all threads
	} sched_state_t;

endpackage
